/* hw/exec_pkg.sv */
package exec_pkg;

    // ==================================================
    // Widths and basic types
    // ==================================================

    localparam int xlen     = 32;
    localparam int tag_bits = 6;
    // Two sources each for ALU, branch and multiplier
    localparam int num_srcs = 6;

    typedef logic [xlen-1:0]     data_t;
    typedef logic [tag_bits-1:0] tag_t;

    // ==================================================
    // Function encodings
    // ==================================================

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sltu,
        alu_sll,
        alu_srl
    } alu_func_e;

    // Same values as RISC-V funct3
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_func_e;

    typedef enum logic [0:0] {
        mult_mul   = 1'b0,
        mult_mulhu = 1'b1
    } mult_func_e;

    // ==================================================
    // Instruction word, two decodings
    // ==================================================

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_form_t;

    // Immediate bits scattered around rs1/rs2
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_form_t;

    typedef union packed {
        i_form_t i_form;
        b_form_t b_form;
    } rv_inst_u;

    // ==================================================
    // Issue, CDB and result bundles
    // ==================================================

    // 40 bits
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        logic  ready;
        data_t value;
    } src_t;

    typedef struct packed {
        logic      valid;
        tag_t      dest_tag;
        alu_func_e func;
        logic      opb_is_imm;
        rv_inst_u  inst;
        src_t      src1;
        src_t      src2;
    } alu_issue_t;

    typedef struct packed {
        logic     valid;
        tag_t     dest_tag;
        br_func_e func;
        data_t    pc;
        rv_inst_u inst;
        src_t     src1;
        src_t     src2;
    } br_issue_t;

    typedef struct packed {
        logic       valid;
        tag_t       dest_tag;
        mult_func_e func;
        src_t       src1;
        src_t       src2;
    } mult_issue_t;

    // 39 bits
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        data_t data;
    } cdb_entry_t;

    // Unit outputs share the CDB layout
    typedef cdb_entry_t fu_result_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        data_t target;
    } br_result_t;

endpackage

/* hw/phys_reg_file.sv */
module phys_reg_file #(
    parameter int PHYS_REGS = 64,
    parameter int CDB_PORTS = 2
) (
    input  logic                                      clock,
    input  logic                                      reset,
    input  exec_pkg::cdb_entry_t [CDB_PORTS-1:0]      cdb_in,
    input  exec_pkg::tag_t [exec_pkg::num_srcs-1:0]   rd_tag,
    output exec_pkg::data_t [exec_pkg::num_srcs-1:0]  rd_data
);
    import exec_pkg::*;

    data_t regs [PHYS_REGS];

    // Writes from every valid CDB port
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < PHYS_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (cdb_in[p].valid) begin
                    regs[cdb_in[p].tag] <= cdb_in[p].data;
                end
            end
        end
    end

    // Asynchronous read, one port per source
    always_comb begin
        for (int s = 0; s < num_srcs; s++) begin
            rd_data[s] = regs[rd_tag[s]];
        end
    end

    // CDB arbiter must hand out distinct tags
    for (genvar a = 0; a < CDB_PORTS; a++) begin : g_cdb_a
        for (genvar b = a + 1; b < CDB_PORTS; b++) begin : g_cdb_b
            a_unique_tag : assert property (
                @(posedge clock) disable iff (reset)
                !(cdb_in[a].valid && cdb_in[b].valid && cdb_in[a].tag == cdb_in[b].tag)
            ) else $error("CDB ports %0d and %0d write the same tag", a, b);
        end
    end

endmodule

/* hw/operand_resolve.sv */
module operand_resolve #(
    parameter int CDB_PORTS = 2
) (
    input  exec_pkg::src_t [exec_pkg::num_srcs-1:0]   src,
    input  exec_pkg::cdb_entry_t [CDB_PORTS-1:0]      cdb_in,
    input  exec_pkg::data_t [exec_pkg::num_srcs-1:0]  rf_data,
    output exec_pkg::tag_t [exec_pkg::num_srcs-1:0]   rd_tag,
    output exec_pkg::data_t [exec_pkg::num_srcs-1:0]  operand
);
    import exec_pkg::*;

    logic  [num_srcs-1:0] cdb_hit;
    data_t [num_srcs-1:0] cdb_data;

    // Register file always read by the source tag
    always_comb begin
        for (int s = 0; s < num_srcs; s++) begin
            rd_tag[s] = src[s].tag;
        end
    end

    // Same-cycle tag match on each CDB port
    always_comb begin
        for (int s = 0; s < num_srcs; s++) begin
            cdb_hit[s]  = 1'b0;
            cdb_data[s] = '0;
            for (int p = 0; p < CDB_PORTS; p++) begin
                if (cdb_in[p].valid && cdb_in[p].tag == src[s].tag) begin
                    cdb_hit[s]  = 1'b1;
                    cdb_data[s] = cdb_in[p].data;
                end
            end
        end
    end

    // Stored value first, then CDB, then register file
    always_comb begin
        for (int s = 0; s < num_srcs; s++) begin
            if (src[s].ready) begin
                operand[s] = src[s].value;
            end else if (cdb_hit[s]) begin
                operand[s] = cdb_data[s];
            end else begin
                // Register file still holds the old value this cycle
                operand[s] = rf_data[s];
            end
        end
    end

endmodule

/* hw/alu.sv */
module alu (
    input  exec_pkg::alu_issue_t  issue,
    input  exec_pkg::data_t       opa,
    input  exec_pkg::data_t       opb_reg,
    output exec_pkg::fu_result_t  result
);
    import exec_pkg::*;

    data_t      imm;
    data_t      opb;
    data_t      value;
    logic [4:0] shamt;

    // Sign-extended I immediate
    assign imm = {{(xlen - 12){issue.inst.i_form.imm[11]}}, issue.inst.i_form.imm};

    // Operand B source
    assign opb   = issue.opb_is_imm ? imm : opb_reg;
    assign shamt = opb[4:0];

    always_comb begin
        case (issue.func)
            alu_add:  value = opa + opb;
            alu_sub:  value = opa - opb;
            alu_and:  value = opa & opb;
            alu_or:   value = opa | opb;
            alu_xor:  value = opa ^ opb;
            // Set-less-than, result in bit 0
            alu_slt:  value = {{(xlen - 1){1'b0}}, $signed(opa) < $signed(opb)};
            alu_sltu: value = {{(xlen - 1){1'b0}}, opa < opb};
            alu_sll:  value = opa << shamt;
            alu_srl:  value = opa >> shamt;
            default:  value = '0;
        endcase
    end

    // Result leaves with the destination tag
    assign result = '{valid: issue.valid, tag: issue.dest_tag, data: value};

endmodule

/* hw/branch_unit.sv */
module branch_unit (
    input  exec_pkg::br_issue_t   issue,
    input  exec_pkg::data_t       rs1,
    input  exec_pkg::data_t       rs2,
    output exec_pkg::br_result_t  result
);
    import exec_pkg::*;

    data_t b_imm;
    logic  equal;
    logic  signed_lt;
    logic  unsigned_lt;
    logic  taken;

    // Reassemble B immediate, bit 0 always zero
    assign b_imm = {{(xlen - 13){issue.inst.b_form.imm_12}}, issue.inst.b_form.imm_12,
                    issue.inst.b_form.imm_11, issue.inst.b_form.imm_10_5,
                    issue.inst.b_form.imm_4_1, 1'b0};

    // Shared comparators
    assign equal       = (rs1 == rs2);
    assign signed_lt   = ($signed(rs1) < $signed(rs2));
    assign unsigned_lt = (rs1 < rs2);

    always_comb begin
        case (issue.func)
            br_beq:  taken = equal;
            br_bne:  taken = !equal;
            br_blt:  taken = signed_lt;
            br_bge:  taken = !signed_lt;
            br_bltu: taken = unsigned_lt;
            br_bgeu: taken = !unsigned_lt;
            default: taken = 1'b0;
        endcase
    end

    assign result = '{valid: issue.valid, taken: taken, target: issue.pc + b_imm};

endmodule

/* hw/mult_datapath.sv */
module mult_datapath #(
    parameter int STEP_BITS = 4
) (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   load,
    input  logic                   step,
    input  exec_pkg::mult_issue_t  issue,
    input  exec_pkg::data_t        rs1,
    input  exec_pkg::data_t        rs2,
    output exec_pkg::tag_t         tag,
    output exec_pkg::data_t        data
);
    import exec_pkg::*;

    logic [2*xlen-1:0] mcand;
    data_t             mplier;
    logic [2*xlen-1:0] partial;
    logic [2*xlen-1:0] acc;
    mult_func_e        func;

    // Multiplicand walks left, multiplier walks right
    always_ff @(posedge clock) begin
        if (load) begin
            mcand  <= {{xlen{1'b0}}, rs1};
            mplier <= rs2;
            tag    <= issue.dest_tag;
            func   <= issue.func;
        end else if (step) begin
            mcand  <= mcand << STEP_BITS;
            mplier <= mplier >> STEP_BITS;
        end
    end

    // Partial product registered, added one step later
    // Extra step at the end drains the last partial product
    always_ff @(posedge clock) begin
        if (reset || load) begin
            partial <= '0;
            acc     <= '0;
        end else if (step) begin
            partial <= mcand * mplier[STEP_BITS-1:0];
            acc     <= acc + partial;
        end
    end

    // mul takes low half, mulhu the high half
    assign data = (func == mult_mulhu) ? acc[2*xlen-1:xlen] : acc[xlen-1:0];

endmodule

/* hw/mult_counter.sv */
module mult_counter #(
    parameter int STEP_BITS = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic clear,
    input  logic step,
    output logic last
);
    import exec_pkg::*;

    // Multiplier chunks, plus one drain step
    localparam int steps    = xlen / STEP_BITS;
    localparam int cnt_bits = $clog2(steps + 1);

    logic [cnt_bits-1:0] count;

    if (xlen % STEP_BITS != 0) begin : g_bad_step
        $error("STEP_BITS must divide the data width");
    end

    always_ff @(posedge clock) begin
        if (reset || clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    assign last = step && (count == cnt_bits'(steps));

endmodule

/* hw/mult_ctrl.sv */
module mult_ctrl (
    input  logic clock,
    input  logic reset,
    input  logic mispredict,
    input  logic start,
    input  logic last,
    input  logic mult_ack,
    output logic load,
    output logic step,
    output logic clear,
    output logic mult_req,
    output logic mult_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_compute,
        st_req,
        st_wait_ack_low
    } state_e;

    state_e state;
    state_e state_next;

    // ==================================================
    // State register and next state
    // ==================================================

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle:         if (start) state_next = st_compute;
            st_compute:      if (last) state_next = st_req;
            // Ack seen in phase 2 so req drops
            st_req:          if (mult_ack) state_next = st_wait_ack_low;
            // Arbiter released ack in phase 4
            st_wait_ack_low: if (!mult_ack) state_next = st_idle;
            default:         state_next = st_idle;
        endcase
        // Flush wins from any state
        if (mispredict) begin
            state_next = st_idle;
        end
    end

    // ==================================================
    // Outputs to counter, datapath and arbiter
    // ==================================================

    assign load      = (state == st_idle) && start && !mispredict;
    assign step      = (state == st_compute);
    assign clear     = (state == st_idle);
    assign mult_req  = (state == st_req);
    assign mult_busy = (state != st_idle);

    // Req holds through back-pressure unless flushed
    a_req_held : assert property (
        @(posedge clock) disable iff (reset)
        mult_req && !mult_ack && !mispredict |=> mult_req
    ) else $error("mult_req dropped before ack");

endmodule

/* hw/stage_execute.sv */
module stage_execute #(
    parameter int PHYS_REGS = 64,
    parameter int STEP_BITS = 4,
    parameter int CDB_PORTS = 2
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  mispredict,
    input  exec_pkg::alu_issue_t                  alu_issue,
    input  exec_pkg::br_issue_t                   br_issue,
    input  exec_pkg::mult_issue_t                 mult_issue,
    input  exec_pkg::cdb_entry_t [CDB_PORTS-1:0]  cdb_in,
    input  logic                                  mult_ack,
    output exec_pkg::fu_result_t                  alu_out,
    output exec_pkg::br_result_t                  br_out,
    output exec_pkg::fu_result_t                  mult_out,
    output logic                                  mult_busy
);
    import exec_pkg::*;

    // Slots 0/1 ALU, 2/3 branch, 4/5 multiplier
    src_t  [num_srcs-1:0] srcs;
    tag_t  [num_srcs-1:0] rd_tag;
    data_t [num_srcs-1:0] rf_data;
    data_t [num_srcs-1:0] operand;

    logic  mult_load;
    logic  mult_step;
    logic  mult_clear;
    logic  mult_last;
    logic  mult_req;
    tag_t  mult_tag;
    data_t mult_data;

    // ==================================================
    // Operand read and forwarding
    // ==================================================

    assign srcs[0] = alu_issue.src1;
    assign srcs[1] = alu_issue.src2;
    assign srcs[2] = br_issue.src1;
    assign srcs[3] = br_issue.src2;
    assign srcs[4] = mult_issue.src1;
    assign srcs[5] = mult_issue.src2;

    phys_reg_file #(.PHYS_REGS(PHYS_REGS), .CDB_PORTS(CDB_PORTS)) phys_reg_file_i (
        .clock   (clock),
        .reset   (reset),
        .cdb_in  (cdb_in),
        .rd_tag  (rd_tag),
        .rd_data (rf_data)
    );

    operand_resolve #(.CDB_PORTS(CDB_PORTS)) operand_resolve_i (
        .src     (srcs),
        .cdb_in  (cdb_in),
        .rf_data (rf_data),
        .rd_tag  (rd_tag),
        .operand (operand)
    );

    // ==================================================
    // Single-cycle units
    // ==================================================

    alu alu_i (
        .issue   (alu_issue),
        .opa     (operand[0]),
        .opb_reg (operand[1]),
        .result  (alu_out)
    );

    branch_unit branch_unit_i (
        .issue  (br_issue),
        .rs1    (operand[2]),
        .rs2    (operand[3]),
        .result (br_out)
    );

    // ==================================================
    // Iterative multiplier
    // ==================================================

    mult_ctrl mult_ctrl_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .start      (mult_issue.valid),
        .last       (mult_last),
        .mult_ack   (mult_ack),
        .load       (mult_load),
        .step       (mult_step),
        .clear      (mult_clear),
        .mult_req   (mult_req),
        .mult_busy  (mult_busy)
    );

    mult_counter #(.STEP_BITS(STEP_BITS)) mult_counter_i (
        .clock (clock),
        .reset (reset),
        .clear (mult_clear),
        .step  (mult_step),
        .last  (mult_last)
    );

    mult_datapath #(.STEP_BITS(STEP_BITS)) mult_datapath_i (
        .clock (clock),
        .reset (reset),
        .load  (mult_load),
        .step  (mult_step),
        .issue (mult_issue),
        .rs1   (operand[4]),
        .rs2   (operand[5]),
        .tag   (mult_tag),
        .data  (mult_data)
    );

    // Valid doubles as the handshake request
    assign mult_out = '{valid: mult_req, tag: mult_tag, data: mult_data};

endmodule

/* tb/stage_execute_tb.sv */
module stage_execute_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import exec_pkg::*;

    localparam int phys_regs    = 64;
    localparam int step_bits    = 4;
    localparam int mult_latency = xlen / step_bits + 1;
    localparam int wait_limit   = 40;

    logic                  clock;
    logic                  reset;
    logic                  mispredict;
    alu_issue_t            alu_issue;
    br_issue_t             br_issue;
    mult_issue_t           mult_issue;
    cdb_entry_t [1:0]      cdb_in;
    logic                  mult_ack;
    fu_result_t            alu_out;
    br_result_t            br_out;
    fu_result_t            mult_out;
    logic                  mult_busy;

    // Expected values, set together with the stimulus
    logic  alu_chk;
    tag_t  alu_exp_tag;
    data_t alu_exp_data;
    logic  br_chk;
    logic  br_exp_taken;
    data_t br_exp_target;
    logic  mult_accept_exp;
    tag_t  mult_exp_tag;
    data_t mult_exp_data;

    int alu_errors;
    int br_errors;
    int mult_errors;
    int proto_errors;
    int timeout_errors;
    int seed = 76;
    bit abort;

    // Register file as seen through our own CDB writes
    data_t shadow [phys_regs];

    br_func_e br_funcs [6] = '{br_beq, br_bne, br_blt, br_bge, br_bltu, br_bgeu};

    stage_execute #(.PHYS_REGS(phys_regs), .STEP_BITS(step_bits)) stage_execute_i (
        .clock      (clock),
        .reset      (reset),
        .mispredict (mispredict),
        .alu_issue  (alu_issue),
        .br_issue   (br_issue),
        .mult_issue (mult_issue),
        .cdb_in     (cdb_in),
        .mult_ack   (mult_ack),
        .alu_out    (alu_out),
        .br_out     (br_out),
        .mult_out   (mult_out),
        .mult_busy  (mult_busy)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ==================================================
    // Checks
    // ==================================================

    a_alu_data : assert property (@(posedge clock) disable iff (reset)
        alu_chk |-> alu_out.data == alu_exp_data)
    else begin
        alu_errors++;
        $display("MISMATCH %0t alu_out.data got %h expected %h", $time,
                 $sampled(alu_out.data), $sampled(alu_exp_data));
    end

    a_alu_tag : assert property (@(posedge clock) disable iff (reset)
        alu_chk |-> alu_out.valid && alu_out.tag == alu_exp_tag)
    else begin
        alu_errors++;
        $display("MISMATCH %0t alu_out.tag got %h expected %h", $time,
                 $sampled(alu_out.tag), $sampled(alu_exp_tag));
    end

    a_br_taken : assert property (@(posedge clock) disable iff (reset)
        br_chk |-> br_out.valid && br_out.taken == br_exp_taken)
    else begin
        br_errors++;
        $display("MISMATCH %0t br_out.taken got %b expected %b", $time,
                 $sampled(br_out.taken), $sampled(br_exp_taken));
    end

    a_br_target : assert property (@(posedge clock) disable iff (reset)
        br_chk |-> br_out.target == br_exp_target)
    else begin
        br_errors++;
        $display("MISMATCH %0t br_out.target got %h expected %h", $time,
                 $sampled(br_out.target), $sampled(br_exp_target));
    end

    a_mult_data : assert property (@(posedge clock) disable iff (reset)
        mult_out.valid |-> mult_out.data == mult_exp_data)
    else begin
        mult_errors++;
        $display("MISMATCH %0t mult_out.data got %h expected %h", $time,
                 $sampled(mult_out.data), $sampled(mult_exp_data));
    end

    a_mult_tag : assert property (@(posedge clock) disable iff (reset)
        mult_out.valid |-> mult_out.tag == mult_exp_tag)
    else begin
        mult_errors++;
        $display("MISMATCH %0t mult_out.tag got %h expected %h", $time,
                 $sampled(mult_out.tag), $sampled(mult_exp_tag));
    end

    // Req exactly mult_latency edges after acceptance, flush cancels
    a_mult_late : assert property (@(posedge clock) disable iff (reset || mispredict)
        mult_accept_exp |-> ##(mult_latency + 1) mult_out.valid)
    else begin
        proto_errors++;
        $display("%0t mult_req missing %0d cycles after acceptance", $time, mult_latency);
    end

    a_mult_early : assert property (@(posedge clock) disable iff (reset)
        $rose(mult_out.valid) |-> $past(mult_accept_exp, mult_latency + 1))
    else begin
        proto_errors++;
        $display("%0t mult_req rose without an acceptance %0d cycles before", $time,
                 mult_latency);
    end

    a_accept : assert property (@(posedge clock) disable iff (reset)
        mult_accept_exp |=> mult_busy)
    else begin
        proto_errors++;
        $display("%0t multiply issued while idle was not accepted", $time);
    end

    // Back-pressure holds the result
    a_hold : assert property (@(posedge clock) disable iff (reset)
        mult_out.valid && !mult_ack && !mispredict |=> mult_out.valid && $stable(mult_out))
    else begin
        proto_errors++;
        $display("%0t mult_out changed or dropped while waiting for ack", $time);
    end

    a_release : assert property (@(posedge clock) disable iff (reset)
        $fell(mult_ack) |=> !mult_busy)
    else begin
        proto_errors++;
        $display("%0t mult_busy still high after ack fell", $time);
    end

    a_flush : assert property (@(posedge clock) disable iff (reset)
        mispredict |=> !mult_out.valid && !mult_busy)
    else begin
        proto_errors++;
        $display("%0t multiplier not idle one cycle after mispredict", $time);
    end

    // ==================================================
    // Reference model
    // ==================================================

    function automatic int rand_below(int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // Corner values for signed and unsigned compares
    function automatic data_t edge_value();
        case (rand_below(8))
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hffff_ffff;
            3:       return 32'h7fff_ffff;
            4:       return 32'h8000_0000;
            5:       return 32'h8000_0001;
            default: return $random(seed);
        endcase
    endfunction

    function automatic data_t i_imm(logic [31:0] w);
        return {{20{w[31]}}, w[31:20]};
    endfunction

    // B immediate scattered over imm[12|10:5] and imm[4:1|11]
    function automatic data_t b_imm(logic [31:0] w);
        return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // Stored value, then same-cycle CDB, then register file
    function automatic data_t resolve(src_t s);
        data_t v;
        v = shadow[s.tag];
        for (int p = 0; p < 2; p++) begin
            if (cdb_in[p].valid && cdb_in[p].tag == s.tag) begin
                v = cdb_in[p].data;
            end
        end
        if (s.ready) begin
            v = s.value;
        end
        return v;
    endfunction

    function automatic data_t alu_model(alu_func_e f, data_t a, data_t b);
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            default:  return '0;
        endcase
    endfunction

    function automatic logic branch_model(br_func_e f, data_t a, data_t b);
        case (f)
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Half the time aim a source at a CDB tag
    function automatic src_t rand_src();
        src_t s;
        s.valid = 1'b1;
        s.ready = (rand_below(3) == 0);
        s.value = edge_value();
        if (rand_below(2) == 0) begin
            s.tag = cdb_in[rand_below(2)].tag;
        end else begin
            s.tag = tag_t'(rand_below(16));
        end
        return s;
    endfunction

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    // Two entries with distinct tags
    task automatic drive_cdb();
        int t0;
        t0 = rand_below(16);
        cdb_in[0].valid = (rand_below(4) != 0);
        cdb_in[0].tag   = tag_t'(t0);
        cdb_in[0].data  = edge_value();
        cdb_in[1].valid = (rand_below(4) != 0);
        cdb_in[1].tag   = tag_t'((t0 + 1 + rand_below(15)) % 16);
        cdb_in[1].data  = edge_value();
    endtask

    // Writes land at the coming edge
    task automatic commit_cdb();
        for (int p = 0; p < 2; p++) begin
            if (cdb_in[p].valid) begin
                shadow[cdb_in[p].tag] = cdb_in[p].data;
            end
        end
    endtask

    task automatic run_alu_branch(input int count);
        data_t opb;
        for (int i = 0; i < count; i++) begin
            drive_cdb();
            alu_issue.valid      = 1'b1;
            alu_issue.dest_tag   = tag_t'(rand_below(phys_regs));
            alu_issue.func       = alu_func_e'(4'(rand_below(9)));
            alu_issue.opb_is_imm = (rand_below(2) == 0);
            alu_issue.inst       = $random(seed);
            alu_issue.src1       = rand_src();
            alu_issue.src2       = rand_src();
            opb = alu_issue.opb_is_imm ? i_imm(alu_issue.inst) : resolve(alu_issue.src2);
            alu_exp_data = alu_model(alu_issue.func, resolve(alu_issue.src1), opb);
            alu_exp_tag  = alu_issue.dest_tag;
            alu_chk      = 1'b1;
            br_issue.valid    = 1'b1;
            br_issue.dest_tag = tag_t'(rand_below(phys_regs));
            br_issue.func     = br_funcs[rand_below(6)];
            br_issue.pc       = $random(seed) & 32'hffff_fffc;
            br_issue.inst     = $random(seed);
            br_issue.src1     = rand_src();
            br_issue.src2     = rand_src();
            br_exp_taken  = branch_model(br_issue.func, resolve(br_issue.src1),
                                         resolve(br_issue.src2));
            br_exp_target = br_issue.pc + b_imm(br_issue.inst);
            br_chk        = 1'b1;
            commit_cdb();
            next_cycle();
        end
        alu_issue = '0;
        br_issue  = '0;
        cdb_in    = '0;
        alu_chk   = 1'b0;
        br_chk    = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (mult_busy !== 1'b0 && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (mult_busy !== 1'b0) begin
            timeout_errors++;
            abort = 1'b1;
            $display("%0t timeout waiting for mult_busy to fall", $time);
        end
    endtask

    task automatic wait_req(input logic level);
        int n;
        n = 0;
        while (mult_out.valid !== level && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (mult_out.valid !== level) begin
            timeout_errors++;
            abort = 1'b1;
            $display("%0t timeout waiting for mult_req to become %b", $time, level);
        end
    endtask

    // One cycle of valid issue while idle, operands maybe forwarded
    task automatic issue_multiply();
        logic [2*xlen-1:0] product;
        drive_cdb();
        mult_issue.valid    = 1'b1;
        mult_issue.dest_tag = tag_t'(rand_below(phys_regs));
        mult_issue.func     = mult_func_e'(1'(rand_below(2)));
        mult_issue.src1     = rand_src();
        mult_issue.src2     = rand_src();
        product = 64'(resolve(mult_issue.src1)) * 64'(resolve(mult_issue.src2));
        mult_exp_data   = (mult_issue.func == mult_mulhu) ? product[63:32] : product[31:0];
        mult_exp_tag    = mult_issue.dest_tag;
        mult_accept_exp = 1'b1;
        commit_cdb();
        next_cycle();
        cdb_in          = '0;
        mult_accept_exp = 1'b0;
    endtask

    // Arbiter side, random ack delay in both phases
    task automatic complete_handshake();
        wait_req(1'b1);
        if (!abort) begin
            repeat (rand_below(5)) next_cycle();
            mult_ack = 1'b1;
            wait_req(1'b0);
            repeat (rand_below(4)) next_cycle();
            mult_ack   = 1'b0;
            mult_issue = '0;
            next_cycle();
        end
    endtask

    task automatic run_multiplies(input int count);
        for (int i = 0; i < count; i++) begin
            wait_idle();
            if (abort) break;
            issue_multiply();
            // Competing issue held through busy must be ignored
            mult_issue.dest_tag = tag_t'(rand_below(phys_regs));
            mult_issue.src1     = rand_src();
            mult_issue.src2     = rand_src();
            complete_handshake();
        end
    endtask

    task automatic run_flushes(input int count);
        for (int i = 0; i < count; i++) begin
            wait_idle();
            if (abort) break;
            issue_multiply();
            mult_issue = '0;
            if (i % 2 == 0) begin
                // Still computing
                repeat (rand_below(8)) next_cycle();
            end else begin
                wait_req(1'b1);
                repeat (rand_below(3)) next_cycle();
            end
            mispredict = 1'b1;
            next_cycle();
            mispredict = 1'b0;
            wait_idle();
            if (abort) break;
            issue_multiply();
            complete_handshake();
        end
    endtask

    initial begin
        reset           = 1'b1;
        mispredict      = 1'b0;
        alu_issue       = '0;
        br_issue        = '0;
        mult_issue      = '0;
        cdb_in          = '0;
        mult_ack        = 1'b0;
        alu_chk         = 1'b0;
        br_chk          = 1'b0;
        mult_accept_exp = 1'b0;
        mult_exp_tag    = '0;
        mult_exp_data   = '0;
        for (int r = 0; r < phys_regs; r++) begin
            shadow[r] = '0;
        end
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;
        run_alu_branch(200);
        run_multiplies(12);
        run_flushes(6);
        repeat (3) next_cycle();
        $display("errors: alu %0d branch %0d mult %0d handshake %0d timeout %0d",
                 alu_errors, br_errors, mult_errors, proto_errors, timeout_errors);
        if (alu_errors + br_errors + mult_errors + proto_errors + timeout_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* stage_execute.f */
hw/exec_pkg.sv
hw/phys_reg_file.sv
hw/operand_resolve.sv
hw/alu.sv
hw/branch_unit.sv
hw/mult_datapath.sv
hw/mult_counter.sv
hw/mult_ctrl.sv
hw/stage_execute.sv
tb/stage_execute_tb.sv
